// ==== hdl/mop_pkg.sv ====
package mop_pkg;

  // virtual address and field widths of one memory operation
  localparam int ADDR_W = 44;
  localparam int SZ_W = 5;
  localparam int ATTR_W = 4;
  localparam int TAG_W = 9;

  // refill works on whole pages
  localparam int PAGE_SHIFT = 14;
  localparam int PAGE_W = ADDR_W - PAGE_SHIFT;

  // one lane's operation, also the stored entry word (63 bits)
  typedef struct packed {
    logic              thread;
    logic [ADDR_W-1:0] addr;
    logic [SZ_W-1:0]   sz;
    logic [ATTR_W-1:0] attr;
    logic [TAG_W-1:0]  tag;
  } mop_t;

endpackage

// ==== hdl/mq_ctrl_pkg.sv ====
package mq_ctrl_pkg;

  // datapath is built for exactly two lanes
  localparam int LANES = 2;

  // one bit per lane
  typedef logic [LANES-1:0] lane_mask_t;

  // replay controller states
  typedef enum logic [1:0] {
    IDLE   = 2'd0,
    REFILL = 2'd1,
    ISSUE  = 2'd2
  } replay_state_t;

endpackage

// ==== hdl/miss_entry_ram.sv ====
module miss_entry_ram
  import mop_pkg::*;
#(
  parameter int DEPTH = 4
) (
  input  logic                     clk,
  input  logic                     we_i,
  input  logic [$clog2(DEPTH)-1:0] waddr_i,
  input  mop_t                     wdata_i,
  input  logic [$clog2(DEPTH)-1:0] raddr_i,
  output mop_t                     rdata_o
);

  mop_t mem [DEPTH];

  always_ff @(posedge clk) begin
    if (we_i) begin
      mem[waddr_i] <= wdata_i;
    end
  end

  // read is asynchronous, so a write shows up from the next cycle
  assign rdata_o = mem[raddr_i];

endmodule

// ==== hdl/miss_capture.sv ====
module miss_capture
  import mop_pkg::*, mq_ctrl_pkg::*;
#(
  parameter int DEPTH = 4
) (
  input  logic                     clk,
  input  logic                     rst,
  input  lane_mask_t               miss_i,
  input  logic                     op0_thread_i,
  input  logic [ADDR_W-1:0]        op0_addr_i,
  input  logic [SZ_W-1:0]          op0_sz_i,
  input  logic [ATTR_W-1:0]        op0_attr_i,
  input  logic [TAG_W-1:0]         op0_tag_i,
  input  logic                     op1_thread_i,
  input  logic [ADDR_W-1:0]        op1_addr_i,
  input  logic [SZ_W-1:0]          op1_sz_i,
  input  logic [ATTR_W-1:0]        op1_attr_i,
  input  logic [TAG_W-1:0]         op1_tag_i,
  input  logic                     except_i,
  input  logic                     except_thread_i,
  input  logic                     full_i,
  input  logic [$clog2(DEPTH)-1:0] head_i,
  input  logic                     pop_i,
  output logic                     push_o,
  output logic                     we_o,
  output logic [$clog2(DEPTH)-1:0] waddr_o,
  output mop_t                     entry0_o,
  output mop_t                     entry1_o,
  output lane_mask_t               head_live_o
);

  localparam int PTR_W = $clog2(DEPTH);

  logic [PTR_W-1:0]            wr_ptr_q;
  logic [LANES-1:0][DEPTH-1:0] valid_q;
  logic [LANES-1:0][DEPTH-1:0] kill_q;
  logic [LANES-1:0][DEPTH-1:0] thr_q;
  lane_mask_t                  in_thr;

  assign entry0_o = '{thread: op0_thread_i, addr: op0_addr_i, sz: op0_sz_i,
                      attr: op0_attr_i, tag: op0_tag_i};
  assign entry1_o = '{thread: op1_thread_i, addr: op1_addr_i, sz: op1_sz_i,
                      attr: op1_attr_i, tag: op1_tag_i};
  assign in_thr = {op1_thread_i, op0_thread_i};

  // both lanes go into one entry whenever either lane misses
  assign push_o = (|miss_i) & ~full_i;
  assign we_o = push_o;
  assign waddr_o = wr_ptr_q;

  // a same-cycle exception already hides the head lane
  always_comb begin
    for (int l = 0; l < LANES; l++) begin
      head_live_o[l] = valid_q[l][head_i] & ~kill_q[l][head_i] &
                       ~(except_i & (thr_q[l][head_i] == except_thread_i));
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr_q <= '0;
      valid_q <= '0;
      kill_q <= '0;
    end else begin
      if (push_o) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      for (int l = 0; l < LANES; l++) begin
        if (pop_i) begin
          valid_q[l][head_i] <= 1'b0;
        end
        // mark every stored lane of the faulting thread
        if (except_i) begin
          kill_q[l] <= kill_q[l] | ~(thr_q[l] ^ {DEPTH{except_thread_i}});
        end
        // new entry overrides the stale kill bit at the write slot
        if (push_o) begin
          valid_q[l][wr_ptr_q] <= miss_i[l];
          kill_q[l][wr_ptr_q] <= except_i & (in_thr[l] == except_thread_i);
        end
      end
    end
  end

  // thread tags per slot
  always_ff @(posedge clk) begin
    for (int l = 0; l < LANES; l++) begin
      if (push_o) begin
        thr_q[l][wr_ptr_q] <= in_thr[l];
      end
    end
  end

endmodule

// ==== hdl/replay_ctrl.sv ====
module replay_ctrl
  import mop_pkg::*, mq_ctrl_pkg::*;
#(
  parameter int DEPTH = 4
) (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     push_i,
  input  lane_mask_t               head_live_i,
  input  logic [PAGE_W-1:0]        head_page0_i,
  input  logic [PAGE_W-1:0]        head_page1_i,
  input  logic [ATTR_W-1:0]        head_attr0_i,
  input  logic [ATTR_W-1:0]        head_attr1_i,
  input  logic                     mlb_ack_i,
  output logic [$clog2(DEPTH)-1:0] head_o,
  output logic                     full_o,
  output logic                     skip_o,
  output logic                     pop_o,
  output logic                     issue_o,
  output lane_mask_t               issue_live_o,
  output logic                     mlb_req_o,
  output logic [PAGE_W-1:0]        mlb_page_o,
  output logic [ATTR_W-1:0]        mlb_attr_o
);

  localparam int PTR_W = $clog2(DEPTH);

  replay_state_t    state_q;
  replay_state_t    state_d;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [PTR_W:0]   count_q;
  logic [PTR_W:0]   count_d;
  lane_mask_t       done_q;
  lane_mask_t       pending;
  logic             cur_lane;
  logic             last_ack;
  logic             skip_q;

  // live lanes of the head entry still waiting for a refill
  assign pending = head_live_i & ~done_q;
  assign cur_lane = ~pending[0];

  assign mlb_req_o = (state_q == REFILL) && (pending != '0);
  assign mlb_page_o = cur_lane ? head_page1_i : head_page0_i;
  assign mlb_attr_o = cur_lane ? head_attr1_i : head_attr0_i;
  // ack on lane 1, or on lane 0 with lane 1 not pending
  assign last_ack = mlb_req_o & mlb_ack_i & (cur_lane | ~pending[1]);

  assign pop_o = (state_q == ISSUE);
  assign issue_o = pop_o;
  assign issue_live_o = head_live_i;
  assign head_o = rd_ptr_q;
  assign full_o = (count_q == (PTR_W+1)'(DEPTH));
  assign skip_o = skip_q;

  assign count_d = count_q + (PTR_W+1)'(push_i) - (PTR_W+1)'(pop_o);

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        // entry with nothing live goes straight to issue
        if (count_q != '0) begin
          state_d = (head_live_i == '0) ? ISSUE : REFILL;
        end
      end
      REFILL: begin
        if (pending == '0 || last_ack) begin
          state_d = ISSUE;
        end
      end
      ISSUE: begin
        state_d = (count_d != '0) ? REFILL : IDLE;
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= IDLE;
      rd_ptr_q <= '0;
      count_q <= '0;
      done_q <= '0;
      skip_q <= 1'b0;
    end else begin
      state_q <= state_d;
      count_q <= count_d;
      // stays high through the replay output cycle
      skip_q <= (count_d != '0) | issue_o;
      if (pop_o) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
        done_q <= '0;
      end else if (mlb_req_o && mlb_ack_i) begin
        done_q[cur_lane] <= 1'b1;
      end
    end
  end

endmodule

// ==== hdl/replay_out.sv ====
module replay_out
  import mop_pkg::*, mq_ctrl_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       issue_i,
  input  lane_mask_t issue_live_i,
  input  mop_t       head0_i,
  input  mop_t       head1_i,
  input  lane_mask_t op_en_i,
  input  mop_t       op0_i,
  input  mop_t       op1_i,
  output lane_mask_t out_en_o,
  output mop_t       out0_o,
  output mop_t       out1_o
);

  logic       rep_vld_q;
  lane_mask_t rep_en_q;
  mop_t       rep0_q;
  mop_t       rep1_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      rep_vld_q <= 1'b0;
      rep_en_q <= '0;
    end else begin
      rep_vld_q <= issue_i;
      rep_en_q <= issue_i ? issue_live_i : '0;
    end
  end

  // replayed operation words
  always_ff @(posedge clk) begin
    if (issue_i) begin
      rep0_q <= head0_i;
      rep1_q <= head1_i;
    end
  end

  // replay owns the lanes for one cycle, otherwise straight bypass
  assign out_en_o = rep_vld_q ? rep_en_q : op_en_i;
  assign out0_o = rep_vld_q ? rep0_q : op0_i;
  assign out1_o = rep_vld_q ? rep1_q : op1_i;

endmodule

// ==== hdl/miss_replay_queue.sv ====
module miss_replay_queue
  import mop_pkg::*, mq_ctrl_pkg::*;
#(
  parameter int DEPTH = 4
) (
  input  logic              clk,
  input  logic              rst,
  input  lane_mask_t        miss_i,
  input  lane_mask_t        op_en_i,
  input  logic              op0_thread_i,
  input  logic [ADDR_W-1:0] op0_addr_i,
  input  logic [SZ_W-1:0]   op0_sz_i,
  input  logic [ATTR_W-1:0] op0_attr_i,
  input  logic [TAG_W-1:0]  op0_tag_i,
  input  logic              op1_thread_i,
  input  logic [ADDR_W-1:0] op1_addr_i,
  input  logic [SZ_W-1:0]   op1_sz_i,
  input  logic [ATTR_W-1:0] op1_attr_i,
  input  logic [TAG_W-1:0]  op1_tag_i,
  input  logic              except_i,
  input  logic              except_thread_i,
  input  logic              mlb_ack_i,
  output logic              skip_o,
  output logic              mlb_req_o,
  output logic [PAGE_W-1:0] mlb_page_o,
  output logic [ATTR_W-1:0] mlb_attr_o,
  output lane_mask_t        out_en_o,
  output mop_t              out0_o,
  output mop_t              out1_o
);

  localparam int PTR_W = $clog2(DEPTH);

  logic             push;
  logic             we;
  logic [PTR_W-1:0] waddr;
  logic [PTR_W-1:0] head;
  logic             pop;
  logic             full;
  logic             issue;
  lane_mask_t       head_live;
  lane_mask_t       issue_live;
  mop_t             entry0;
  mop_t             entry1;
  mop_t             head0;
  mop_t             head1;

  miss_capture #(.DEPTH(DEPTH)) u_miss_capture (
    .clk(clk), .rst(rst), .miss_i(miss_i),
    .op0_thread_i(op0_thread_i), .op0_addr_i(op0_addr_i), .op0_sz_i(op0_sz_i),
    .op0_attr_i(op0_attr_i), .op0_tag_i(op0_tag_i),
    .op1_thread_i(op1_thread_i), .op1_addr_i(op1_addr_i), .op1_sz_i(op1_sz_i),
    .op1_attr_i(op1_attr_i), .op1_tag_i(op1_tag_i),
    .except_i(except_i), .except_thread_i(except_thread_i),
    .full_i(full), .head_i(head), .pop_i(pop),
    .push_o(push), .we_o(we), .waddr_o(waddr),
    .entry0_o(entry0), .entry1_o(entry1), .head_live_o(head_live)
  );

  // one RAM per lane, written together
  miss_entry_ram #(.DEPTH(DEPTH)) u_ram0 (
    .clk(clk), .we_i(we), .waddr_i(waddr), .wdata_i(entry0),
    .raddr_i(head), .rdata_o(head0)
  );

  miss_entry_ram #(.DEPTH(DEPTH)) u_ram1 (
    .clk(clk), .we_i(we), .waddr_i(waddr), .wdata_i(entry1),
    .raddr_i(head), .rdata_o(head1)
  );

  replay_ctrl #(.DEPTH(DEPTH)) u_replay_ctrl (
    .clk(clk), .rst(rst), .push_i(push), .head_live_i(head_live),
    .head_page0_i(head0.addr[ADDR_W-1:PAGE_SHIFT]),
    .head_page1_i(head1.addr[ADDR_W-1:PAGE_SHIFT]),
    .head_attr0_i(head0.attr), .head_attr1_i(head1.attr),
    .mlb_ack_i(mlb_ack_i), .head_o(head), .full_o(full), .skip_o(skip_o),
    .pop_o(pop), .issue_o(issue), .issue_live_o(issue_live),
    .mlb_req_o(mlb_req_o), .mlb_page_o(mlb_page_o), .mlb_attr_o(mlb_attr_o)
  );

  // packed capture words double as the bypass operations
  replay_out u_replay_out (
    .clk(clk), .rst(rst), .issue_i(issue), .issue_live_i(issue_live),
    .head0_i(head0), .head1_i(head1), .op_en_i(op_en_i),
    .op0_i(entry0), .op1_i(entry1),
    .out_en_o(out_en_o), .out0_o(out0_o), .out1_o(out1_o)
  );

endmodule

// ==== test/tb_miss_replay_queue.sv ====
module tb_miss_replay_queue
  import mop_pkg::*, mq_ctrl_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int DEPTH = 4;
  localparam int CLK_PERIOD = 8;
  localparam int RESET_CYCLES = 2;
  localparam int NUM_OPS = 400;
  localparam int WATCHDOG_CYCLES = 40 * NUM_OPS;
  localparam int PH_IDLE = 0;
  localparam int PH_REFILL = 1;
  localparam int PH_ISSUE = 2;

  logic              clk;
  logic              rst;
  lane_mask_t        miss;
  lane_mask_t        op_en;
  mop_t              op0_d;
  mop_t              op1_d;
  logic              except_d;
  logic              except_thr_d;
  logic              ack_d;
  logic              skip;
  logic              mlb_req;
  logic [PAGE_W-1:0] mlb_page;
  logic [ATTR_W-1:0] mlb_attr;
  lane_mask_t        out_en;
  mop_t              out0;
  mop_t              out1;

  // reference queue with one element per captured entry
  mop_t        q_op0[$];
  mop_t        q_op1[$];
  lane_mask_t  q_live[$];
  int          phase;
  lane_mask_t  done_mask;
  logic        rep_vld;
  lane_mask_t  rep_en;
  mop_t        rep_op0;
  mop_t        rep_op1;
  logic        skip_exp;
  logic [15:0] lfsr;
  int          pushed;
  int          ack_wait;
  int          ack_delay;

  miss_replay_queue #(.DEPTH(DEPTH)) u_miss_replay_queue (
    .clk(clk), .rst(rst), .miss_i(miss), .op_en_i(op_en),
    .op0_thread_i(op0_d.thread), .op0_addr_i(op0_d.addr), .op0_sz_i(op0_d.sz),
    .op0_attr_i(op0_d.attr), .op0_tag_i(op0_d.tag),
    .op1_thread_i(op1_d.thread), .op1_addr_i(op1_d.addr), .op1_sz_i(op1_d.sz),
    .op1_attr_i(op1_d.attr), .op1_tag_i(op1_d.tag),
    .except_i(except_d), .except_thread_i(except_thr_d), .mlb_ack_i(ack_d),
    .skip_o(skip), .mlb_req_o(mlb_req), .mlb_page_o(mlb_page), .mlb_attr_o(mlb_attr),
    .out_en_o(out_en), .out0_o(out0), .out1_o(out1)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("run stalled, no finish within %0d cycles", WATCHDOG_CYCLES);
    $display("STATUS: FAIL");
    $fatal(1, "watchdog timeout");
  end

  // 16-bit Fibonacci LFSR with taps 16 14 13 11
  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
      lfsr = {lfsr[14:0], fb};
      v = {v[62:0], fb};
    end
    return v;
  endfunction

  // lanes of a pair hit by the exception driven this cycle
  function automatic lane_mask_t thread_hits(input mop_t a, input mop_t b);
    lane_mask_t k;
    k[0] = except_d & (a.thread == except_thr_d);
    k[1] = except_d & (b.thread == except_thr_d);
    return k;
  endfunction

  task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
    assert (got === exp) else begin
      $display("mismatch %s got %h expected %h", name, got, exp);
      $display("STATUS: FAIL");
      $fatal(1, "check failed");
    end
  endtask

  task automatic run_cycle(input logic gen);
    logic [63:0] r;
    lane_mask_t  live_eff;
    lane_mask_t  pend;
    logic        exp_req;
    logic        pop;
    int          size_q;
    int          next_phase;
    @(negedge clk);
    r = rand_bits(63);
    op0_d = r[62:0];
    r = rand_bits(63);
    op1_d = r[62:0];
    r = rand_bits(4);
    miss = '0;
    if (gen && q_op0.size() < DEPTH && r[1:0] == 2'b00) begin
      miss = (r[3:2] == 2'b00) ? 2'b11 : r[3:2];
    end
    r = rand_bits(6);
    except_d = gen && (r[4:0] == 5'd0);
    except_thr_d = r[5];
    r = rand_bits(2);
    // upstream holds issue while skip is up
    op_en = skip_exp ? 2'b00 : r[1:0];
    ack_d = (ack_wait >= ack_delay);
    #1;
    size_q = q_op0.size();
    live_eff = '0;
    if (size_q != 0) begin
      live_eff = q_live[0] & ~thread_hits(q_op0[0], q_op1[0]);
    end
    pend = live_eff & ~done_mask;
    exp_req = (phase == PH_REFILL) && (pend != '0);
    check_val("skip_o", 64'(skip), 64'(skip_exp));
    check_val("mlb_req_o", 64'(mlb_req), 64'(exp_req));
    check_val("out_en_o", 64'(out_en), rep_vld ? 64'(rep_en) : 64'(op_en));
    check_val("out0_o", 64'(out0), rep_vld ? 64'(rep_op0) : 64'(op0_d));
    check_val("out1_o", 64'(out1), rep_vld ? 64'(rep_op1) : 64'(op1_d));
    // lowest pending lane is refilled first
    if (exp_req && pend[0]) begin
      check_val("mlb_page_o", 64'(mlb_page), 64'(q_op0[0].addr[ADDR_W-1:PAGE_SHIFT]));
      check_val("mlb_attr_o", 64'(mlb_attr), 64'(q_op0[0].attr));
    end else if (exp_req) begin
      check_val("mlb_page_o", 64'(mlb_page), 64'(q_op1[0].addr[ADDR_W-1:PAGE_SHIFT]));
      check_val("mlb_attr_o", 64'(mlb_attr), 64'(q_op1[0].attr));
    end
    for (int i = 0; i < size_q; i++) begin
      q_live[i] = q_live[i] & ~thread_hits(q_op0[i], q_op1[i]);
    end
    if (exp_req && ack_d) begin
      if (pend[0]) begin
        done_mask[0] = 1'b1;
      end else begin
        done_mask[1] = 1'b1;
      end
      ack_wait = 0;
      r = rand_bits(3);
      ack_delay = int'(r[2:0]);
    end else begin
      ack_wait = exp_req ? ack_wait + 1 : 0;
    end
    next_phase = phase;
    if (phase == PH_IDLE && size_q != 0) begin
      next_phase = (live_eff == '0) ? PH_ISSUE : PH_REFILL;
    end else if (phase == PH_REFILL && (live_eff & ~done_mask) == '0) begin
      next_phase = PH_ISSUE;
    end
    pop = (phase == PH_ISSUE);
    rep_vld = pop;
    rep_en = pop ? live_eff : 2'b00;
    if (pop) begin
      rep_op0 = q_op0.pop_front();
      rep_op1 = q_op1.pop_front();
      void'(q_live.pop_front());
      done_mask = '0;
    end
    if (miss != '0) begin
      q_op0.push_back(op0_d);
      q_op1.push_back(op1_d);
      q_live.push_back(miss & ~thread_hits(op0_d, op1_d));
      pushed++;
    end
    if (pop) begin
      next_phase = (q_op0.size() != 0) ? PH_REFILL : PH_IDLE;
    end
    phase = next_phase;
    skip_exp = (q_op0.size() != 0) || pop;
  endtask

  initial begin
    rst = 1'b1;
    miss = '0;
    op_en = '0;
    op0_d = '0;
    op1_d = '0;
    except_d = 1'b0;
    except_thr_d = 1'b0;
    ack_d = 1'b0;
    phase = PH_IDLE;
    done_mask = '0;
    rep_vld = 1'b0;
    rep_en = '0;
    rep_op0 = '0;
    rep_op1 = '0;
    skip_exp = 1'b0;
    lfsr = 16'd55237;
    pushed = 0;
    ack_wait = 0;
    ack_delay = 0;
    repeat (RESET_CYCLES) @(negedge clk);
    rst = 1'b0;
    while (pushed < NUM_OPS) begin
      run_cycle(1'b1);
    end
    // drain the queue and idle a few cycles with skip low
    while (q_op0.size() != 0 || rep_vld || skip_exp) begin
      run_cycle(1'b0);
    end
    repeat (4) begin
      run_cycle(1'b0);
    end
    $display("STATUS: PASS");
    $finish;
  end

endmodule

// ==== filelist.f ====
hdl/mop_pkg.sv
hdl/mq_ctrl_pkg.sv
hdl/miss_entry_ram.sv
hdl/miss_capture.sv
hdl/replay_ctrl.sv
hdl/replay_out.sv
hdl/miss_replay_queue.sv
test/tb_miss_replay_queue.sv

// ==== Makefile ====
VERILATOR ?= verilator
FILELIST  ?= filelist.f
TOP       ?= tb_miss_replay_queue
RTL_TOP   ?= miss_replay_queue
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= STATUS: PASS

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell cat $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

sim: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
